// File: build.f
+incdir+hdl
+incdir+sim
hdl/masku_pkg.sv
hdl/masku_if.sv
hdl/masku_sequencer.sv
hdl/mask_distributor.sv
hdl/mask_merge_unit.sv
hdl/masku_top.sv
sim/masku_tb.sv

// File: Bender.yml
package:
  name: masku

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/masku_pkg.sv
      - hdl/masku_if.sv
      - hdl/masku_sequencer.sv
      - hdl/mask_distributor.sv
      - hdl/mask_merge_unit.sv
      - hdl/masku_top.sv
  - target: simulation
    include_dirs:
      - hdl
      - sim
    files:
      - sim/masku_tb.sv

// File: sim/masku_model.svh
/* Reference model of the mask unit: merged words, byte enables,
   write addresses and predicate strobes */

`ifndef MASKU_MODEL_SVH
`define MASKU_MODEL_SVH

`include "masku_defines.svh"

// Bit k of lane l in beat n is element n*128 + l*64 + k
function automatic masku_pkg::elen_t merge_word(input masku_pkg::elen_t a,
                                                input masku_pkg::elen_t b,
                                                input masku_pkg::elen_t m,
                                                input int vl, input logic vm,
                                                input int beat, input int lane);
  masku_pkg::elen_t w;
  int e;
  for (int k = 0; k < `MASKU_ELEN; k++) begin
    e = beat * `MASKU_NR_LANES * `MASKU_ELEN + lane * `MASKU_ELEN + k;
    // Active element takes the ALU result, the rest keeps the old value
    w[k] = ((e < vl) && (vm || m[k])) ? a[k] : b[k];
  end
  return w;
endfunction

// Byte j is written when its first element lies below vl
function automatic masku_pkg::strb_t lane_byte_enable(input int vl, input int beat,
                                                      input int lane);
  masku_pkg::strb_t be;
  for (int j = 0; j < `MASKU_STRB_W; j++) begin
    be[j] = (beat * `MASKU_NR_LANES * `MASKU_ELEN + lane * `MASKU_ELEN + 8 * j) < vl;
  end
  return be;
endfunction

function automatic masku_pkg::vaddr_t beat_address(input masku_pkg::vaddr_t vd,
                                                   input int beat);
  return masku_pkg::vaddr_t'(vd + beat);
endfunction

// Strobe beat s covers elements s*16 .. s*16+15, 8 per lane
function automatic masku_pkg::strb_t pred_strobe(
    input logic [`MASKU_NR_LANES*`MASKU_ELEN-1:0] mbeat,
    input int vl, input int s, input int lane);
  masku_pkg::strb_t st;
  int e;
  for (int j = 0; j < 8; j++) begin
    e = s * `MASKU_NR_LANES * 8 + lane * 8 + j;
    st[j] = mbeat[e % (`MASKU_NR_LANES * `MASKU_ELEN)] && (e < vl);
  end
  return st;
endfunction

`endif

// File: sim/masku_tb.sv
/* Testbench of the mask unit: clock, reset, random lane models,
   compare tasks against the reference model, watchdog and report */

`include "masku_defines.svh"

module masku_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int LANES = `MASKU_NR_LANES;
  localparam int CLK_NS = 4;
  localparam int BEAT_ELEMS = `MASKU_NR_LANES * `MASKU_ELEN;
  localparam int MAX_BEATS = `MASKU_MAX_VL / BEAT_ELEMS;
  // 16 elements per strobe beat
  localparam int MAX_STRB = `MASKU_MAX_VL / (LANES * 8);
  localparam int N_PER_TEST = 6;
  localparam int N_INSN = 4 * N_PER_TEST;
  localparam int WATCHDOG_NS = N_INSN * MAX_STRB * 200 * CLK_NS;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic insn_valid_i;
  logic insn_ready_o;
  masku_pkg::masku_op_e insn_op_i;
  masku_pkg::vl_t insn_vl_i;
  logic insn_vm_i;
  masku_pkg::vaddr_t insn_vd_i;
  masku_pkg::vid_t insn_id_i;
  logic done_valid_o;
  masku_pkg::vid_t done_id_o;
  masku_pkg::elen_t [LANES-1:0] a_i = '0;
  logic [LANES-1:0] a_valid_i = '0;
  logic [LANES-1:0] a_ready_o;
  masku_pkg::elen_t [LANES-1:0] b_i = '0;
  logic [LANES-1:0] b_valid_i = '0;
  logic [LANES-1:0] b_ready_o;
  masku_pkg::elen_t [LANES-1:0] m_i = '0;
  logic [LANES-1:0] m_valid_i = '0;
  logic m_ready_o;
  logic [LANES-1:0] wr_req_o;
  logic [LANES-1:0] wr_gnt_i = '0;
  masku_pkg::vaddr_t [LANES-1:0] wr_addr_o;
  masku_pkg::elen_t [LANES-1:0] wr_wdata_o;
  masku_pkg::strb_t [LANES-1:0] wr_be_o;
  masku_pkg::vid_t [LANES-1:0] wr_id_o;
  masku_pkg::strb_t [LANES-1:0] mask_o;
  logic [LANES-1:0] mask_valid_o;
  logic [LANES-1:0] mask_ready_i = '0;

  // Operand beats offered by the lanes for the current instruction
  masku_pkg::elen_t a_mem [MAX_BEATS][LANES];
  masku_pkg::elen_t b_mem [MAX_BEATS][LANES];
  masku_pkg::elen_t m_mem [MAX_BEATS][LANES];
  int a_n = 0;
  int b_n = 0;
  int m_n = 0;
  int a_idx = 0;
  int b_idx = 0;
  int m_idx = 0;

  // Expected results and per-lane progress
  masku_pkg::elen_t exp_word [MAX_BEATS][LANES];
  masku_pkg::strb_t exp_be [MAX_BEATS][LANES];
  masku_pkg::vaddr_t exp_addr [MAX_BEATS];
  masku_pkg::strb_t exp_strb [MAX_STRB][LANES];
  int wr_n = 0;
  int strb_n = 0;
  int wr_cnt [LANES] = '{default: 0};
  int strb_cnt [LANES] = '{default: 0};

  masku_pkg::vid_t cur_id = '0;
  bit busy = 1'b0;
  bit got_done = 1'b0;
  bit heavy_stall = 1'b0;
  int insn_count = 0;
  int err_count = 0;
  int tests_run = 0;
  int tests_failed = 0;

  `include "masku_model.svh"

  masku_top masku_top_i (.*);

  always #(CLK_NS / 2) clk_i = ~clk_i;

  function automatic bit chance(input int unsigned percent);
    return $urandom_range(99) < percent;
  endfunction

  task automatic report_error(input string msg);
    err_count++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  task automatic show_mismatch(input string name, input string got, input string exp);
    err_count++;
    $display("FAILED at %0t ns: %s = %s, expected %s", $time, name, got, exp);
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      show_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    end
  endtask

  task automatic check_word(input string name, input masku_pkg::elen_t got,
                            input masku_pkg::elen_t exp);
    if (got !== exp) begin
      show_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    end
  endtask

  task automatic check_be(input string name, input masku_pkg::strb_t got,
                          input masku_pkg::strb_t exp);
    if (got !== exp) begin
      show_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    end
  endtask

  task automatic check_addr(input string name, input masku_pkg::vaddr_t got,
                            input masku_pkg::vaddr_t exp);
    if (got !== exp) begin
      show_mismatch(name, $sformatf("%h", got), $sformatf("%h", exp));
    end
  endtask

  task automatic check_mask(input string name, input masku_pkg::strb_t got,
                            input masku_pkg::strb_t exp);
    if (got !== exp) begin
      show_mismatch(name, $sformatf("%b", got), $sformatf("%b", exp));
    end
  endtask

  task automatic check_done(input string name, input masku_pkg::vid_t got,
                            input masku_pkg::vid_t exp);
    if (got !== exp) begin
      show_mismatch(name, $sformatf("%0d", got), $sformatf("%0d", exp));
    end
  endtask

  // Lane models sample pre-edge outputs, then drive new inputs
  always @(posedge clk_i) begin : lane_models
    logic a_fire;
    logic b_fire;
    logic m_fire;
    if (rst_ni) begin
      for (int l = 0; l < LANES; l++) begin
        if (wr_req_o[l] && wr_gnt_i[l]) begin
          if (wr_cnt[l] >= wr_n) begin
            report_error($sformatf("unexpected write on lane %0d", l));
          end else begin
            check_word($sformatf("wr_wdata_o[%0d]", l), wr_wdata_o[l], exp_word[wr_cnt[l]][l]);
            check_be($sformatf("wr_be_o[%0d]", l), wr_be_o[l], exp_be[wr_cnt[l]][l]);
            check_addr($sformatf("wr_addr_o[%0d]", l), wr_addr_o[l], exp_addr[wr_cnt[l]]);
            check_done($sformatf("wr_id_o[%0d]", l), wr_id_o[l], cur_id);
            wr_cnt[l]++;
          end
        end
        if (mask_valid_o[l] && mask_ready_i[l]) begin
          if (strb_cnt[l] >= strb_n) begin
            report_error($sformatf("unexpected strobe beat on lane %0d", l));
          end else begin
            check_mask($sformatf("mask_o[%0d]", l), mask_o[l], exp_strb[strb_cnt[l]][l]);
            strb_cnt[l]++;
          end
        end
      end
      // Done pulse closes the instruction
      if (done_valid_o) begin
        if (!busy) begin
          report_error("done pulse with no instruction in flight");
        end else begin
          check_done("done_id_o", done_id_o, cur_id);
          for (int l = 0; l < LANES; l++) begin
            if (wr_cnt[l] != wr_n || strb_cnt[l] != strb_n) begin
              report_error($sformatf("done pulse before lane %0d retired every beat", l));
            end
          end
          busy = 1'b0;
          got_done = 1'b1;
        end
      end else if (busy && insn_ready_o) begin
        report_error("insn_ready_o high while an instruction is in flight");
      end
      if (insn_valid_i && insn_ready_o) begin
        busy = 1'b1;
      end
      a_fire = &(a_valid_i & a_ready_o);
      b_fire = &(b_valid_i & b_ready_o);
      m_fire = (&m_valid_i) && m_ready_o;
      if (a_fire) begin
        a_idx++;
      end
      if (b_fire) begin
        b_idx++;
      end
      if (m_fire) begin
        m_idx++;
      end
    end
    for (int l = 0; l < LANES; l++) begin
      // Valid is sticky until the beat transfers
      if (rst_ni && a_idx < a_n) begin
        a_i[l] <= a_mem[a_idx][l];
        a_valid_i[l] <= (a_valid_i[l] && !a_fire) || chance(heavy_stall ? 40 : 70);
      end else begin
        a_valid_i[l] <= 1'b0;
      end
      if (rst_ni && b_idx < b_n) begin
        b_i[l] <= b_mem[b_idx][l];
        b_valid_i[l] <= (b_valid_i[l] && !b_fire) || chance(heavy_stall ? 40 : 70);
      end else begin
        b_valid_i[l] <= 1'b0;
      end
      if (rst_ni && m_idx < m_n) begin
        m_i[l] <= m_mem[m_idx][l];
        m_valid_i[l] <= (m_valid_i[l] && !m_fire) || chance(heavy_stall ? 40 : 70);
      end else begin
        m_valid_i[l] <= 1'b0;
      end
      wr_gnt_i[l] <= rst_ni && chance(heavy_stall ? 25 : 75);
      mask_ready_i[l] <= rst_ni && chance(heavy_stall ? 25 : 75);
    end
  end

  // Prepare operands and expected results, then issue and wait for done
  task automatic run_insn(input masku_pkg::masku_op_e op, input logic vm);
    int vl;
    int nbeat;
    masku_pkg::vaddr_t vd;
    logic [BEAT_ELEMS-1:0] mbeat;
    vl = $urandom_range(`MASKU_MAX_VL);
    vd = masku_pkg::vaddr_t'($urandom);
    nbeat = (vl + BEAT_ELEMS - 1) / BEAT_ELEMS;
    @(negedge clk_i);
    cur_id = masku_pkg::vid_t'(insn_count);
    insn_count++;
    for (int n = 0; n < MAX_BEATS; n++) begin
      for (int l = 0; l < LANES; l++) begin
        a_mem[n][l] = {$urandom, $urandom};
        b_mem[n][l] = {$urandom, $urandom};
        m_mem[n][l] = {$urandom, $urandom};
      end
    end
    if (op == masku_pkg::OP_MASK_LOGIC) begin
      a_n = nbeat;
      b_n = nbeat;
      m_n = vm ? 0 : nbeat;
      wr_n = nbeat;
      strb_n = 0;
      for (int n = 0; n < nbeat; n++) begin
        exp_addr[n] = beat_address(vd, n);
        for (int l = 0; l < LANES; l++) begin
          exp_word[n][l] = merge_word(a_mem[n][l], b_mem[n][l], m_mem[n][l], vl, vm, n, l);
          exp_be[n][l] = lane_byte_enable(vl, n, l);
        end
      end
    end else begin
      a_n = 0;
      b_n = 0;
      m_n = nbeat;
      wr_n = 0;
      strb_n = (vl + LANES * 8 - 1) / (LANES * 8);
      for (int s = 0; s < strb_n; s++) begin
        for (int l = 0; l < LANES; l++) begin
          mbeat[l*`MASKU_ELEN +: `MASKU_ELEN] = m_mem[s / 8][l];
        end
        for (int l = 0; l < LANES; l++) begin
          exp_strb[s][l] = pred_strobe(mbeat, vl, s, l);
        end
      end
    end
    a_idx = 0;
    b_idx = 0;
    m_idx = 0;
    wr_cnt = '{default: 0};
    strb_cnt = '{default: 0};
    got_done = 1'b0;
    @(posedge clk_i);
    insn_valid_i <= 1'b1;
    insn_op_i <= op;
    insn_vl_i <= masku_pkg::vl_t'(vl);
    insn_vm_i <= vm;
    insn_vd_i <= vd;
    insn_id_i <= cur_id;
    do begin
      @(posedge clk_i);
    end while (!insn_ready_o);
    insn_valid_i <= 1'b0;
    wait (got_done);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, err_count - errs_before);
    end
  endtask

  // kind 0 merge vm high, 1 merge vm low, 2 predicate, 3 mixed
  task automatic run_test(input string name, input int kind, input bit heavy);
    int errs_before;
    errs_before = err_count;
    heavy_stall = heavy;
    for (int i = 0; i < N_PER_TEST; i++) begin
      case (kind)
        0: run_insn(masku_pkg::OP_MASK_LOGIC, 1'b1);
        1: run_insn(masku_pkg::OP_MASK_LOGIC, 1'b0);
        2: run_insn(masku_pkg::OP_PREDICATE, 1'b1);
        default: begin
          if (chance(50)) begin
            run_insn(masku_pkg::OP_PREDICATE, 1'b1);
          end else begin
            run_insn(masku_pkg::OP_MASK_LOGIC, logic'(chance(50)));
          end
        end
      endcase
    end
    finish_test(name, errs_before);
  endtask

  task automatic check_reset_state();
    int errs_before;
    errs_before = err_count;
    check_flag("insn_ready_o", insn_ready_o, 1'b1);
    check_flag("m_ready_o", m_ready_o, 1'b0);
    check_flag("done_valid_o", done_valid_o, 1'b0);
    for (int l = 0; l < LANES; l++) begin
      check_flag($sformatf("wr_req_o[%0d]", l), wr_req_o[l], 1'b0);
      check_flag($sformatf("mask_valid_o[%0d]", l), mask_valid_o[l], 1'b0);
      check_flag($sformatf("a_ready_o[%0d]", l), a_ready_o[l], 1'b0);
      check_flag($sformatf("b_ready_o[%0d]", l), b_ready_o[l], 1'b0);
    end
    finish_test("reset_state", errs_before);
  endtask

  initial begin : main
    void'($urandom(81899));
    rst_ni = 1'b0;
    insn_valid_i = 1'b0;
    insn_op_i = masku_pkg::OP_MASK_LOGIC;
    insn_vl_i = '0;
    insn_vm_i = 1'b1;
    insn_vd_i = '0;
    insn_id_i = '0;
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_reset_state();
    run_test("mask_logic_vm_high", 0, 1'b0);
    run_test("mask_logic_vm_low", 1, 1'b0);
    run_test("predicate", 2, 1'b0);
    run_test("back_pressure", 3, 1'b1);
    // Idle tail catches stray done pulses
    repeat (10) @(posedge clk_i);
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: hdl/masku_top.sv
/* Mask unit top level: sequencer, merge unit and distributor
   behind plain ports */

`include "masku_defines.svh"

module masku_top (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Instruction
  input  logic                                      insn_valid_i,
  output logic                                      insn_ready_o,
  input  masku_pkg::masku_op_e                      insn_op_i,
  input  masku_pkg::vl_t                            insn_vl_i,
  input  logic                                      insn_vm_i,
  input  masku_pkg::vaddr_t                         insn_vd_i,
  input  masku_pkg::vid_t                           insn_id_i,
  output logic                                      done_valid_o,
  output masku_pkg::vid_t                           done_id_o,
  // Operands from the lanes
  input  masku_pkg::elen_t [`MASKU_NR_LANES-1:0]    a_i,
  input  logic [`MASKU_NR_LANES-1:0]                a_valid_i,
  output logic [`MASKU_NR_LANES-1:0]                a_ready_o,
  input  masku_pkg::elen_t [`MASKU_NR_LANES-1:0]    b_i,
  input  logic [`MASKU_NR_LANES-1:0]                b_valid_i,
  output logic [`MASKU_NR_LANES-1:0]                b_ready_o,
  input  masku_pkg::elen_t [`MASKU_NR_LANES-1:0]    m_i,
  input  logic [`MASKU_NR_LANES-1:0]                m_valid_i,
  output logic                                      m_ready_o,
  // Result writes
  output logic [`MASKU_NR_LANES-1:0]                wr_req_o,
  input  logic [`MASKU_NR_LANES-1:0]                wr_gnt_i,
  output masku_pkg::vaddr_t [`MASKU_NR_LANES-1:0]   wr_addr_o,
  output masku_pkg::elen_t [`MASKU_NR_LANES-1:0]    wr_wdata_o,
  output masku_pkg::strb_t [`MASKU_NR_LANES-1:0]    wr_be_o,
  output masku_pkg::vid_t [`MASKU_NR_LANES-1:0]     wr_id_o,
  // Strobes to the functional units
  output masku_pkg::strb_t [`MASKU_NR_LANES-1:0]    mask_o,
  output logic [`MASKU_NR_LANES-1:0]                mask_valid_o,
  input  logic [`MASKU_NR_LANES-1:0]                mask_ready_i
);

  masku_pkg::masku_insn_t insn;
  logic merge_m_ready;
  logic dist_m_ready;

  insn_if insn_bus ();
  vrf_wr_if wr_bus ();

  // Pack the instruction fields
  assign insn = '{op: insn_op_i, vl: insn_vl_i, vm: insn_vm_i, vd: insn_vd_i, id: insn_id_i};

  masku_sequencer i_sequencer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn_valid_i (insn_valid_i),
    .insn_ready_o (insn_ready_o),
    .insn_i       (insn),
    .done_valid_o (done_valid_o),
    .done_id_o    (done_id_o),
    .insn_o       (insn_bus.seq)
  );

  mask_merge_unit i_merge (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .insn      (insn_bus.path_logic),
    .a_i       (a_i),
    .a_valid_i (a_valid_i),
    .a_ready_o (a_ready_o),
    .b_i       (b_i),
    .b_valid_i (b_valid_i),
    .b_ready_o (b_ready_o),
    .m_i       (m_i),
    .m_valid_i (m_valid_i),
    .m_ready_o (merge_m_ready),
    .wr        (wr_bus.src)
  );

  mask_distributor i_distributor (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .insn         (insn_bus.path_pred),
    .m_i          (m_i),
    .m_valid_i    (m_valid_i),
    .m_ready_o    (dist_m_ready),
    .mask_o       (mask_o),
    .mask_valid_o (mask_valid_o),
    .mask_ready_i (mask_ready_i)
  );

  // Only the active path raises its ready
  assign m_ready_o = merge_m_ready | dist_m_ready;

  // Write bus onto the lane ports
  assign wr_req_o   = wr_bus.req;
  assign wr_addr_o  = wr_bus.addr;
  assign wr_wdata_o = wr_bus.wdata;
  assign wr_be_o    = wr_bus.be;
  assign wr_id_o    = wr_bus.id;
  assign wr_bus.gnt = wr_gnt_i;

endmodule

// File: hdl/mask_merge_unit.sv
/* Mask-logic path: bit-enable merge of the ALU result with the old
   destination word, two-entry result queue per lane */

`include "masku_defines.svh"

module mask_merge_unit (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  insn_if.path_logic                                insn,
  // ALU result
  input  masku_pkg::elen_t [`MASKU_NR_LANES-1:0]    a_i,
  input  logic [`MASKU_NR_LANES-1:0]                a_valid_i,
  output logic [`MASKU_NR_LANES-1:0]                a_ready_o,
  // Old destination register
  input  masku_pkg::elen_t [`MASKU_NR_LANES-1:0]    b_i,
  input  logic [`MASKU_NR_LANES-1:0]                b_valid_i,
  output logic [`MASKU_NR_LANES-1:0]                b_ready_o,
  // Mask operand
  input  masku_pkg::elen_t [`MASKU_NR_LANES-1:0]    m_i,
  input  logic [`MASKU_NR_LANES-1:0]                m_valid_i,
  output logic                                      m_ready_o,
  // Result writes
  vrf_wr_if.src                                     wr
);

  localparam int unsigned LANES = `MASKU_NR_LANES;
  localparam int unsigned ELEN = `MASKU_ELEN;
  localparam int unsigned DEPTH = `MASKU_QUEUE_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  // One element per bit across all lanes
  localparam int unsigned BEAT_ELEMS = LANES * ELEN;
  localparam int unsigned BEAT_W = $clog2(`MASKU_MAX_VL / BEAT_ELEMS);

  masku_pkg::path_state_e state_q;
  masku_pkg::vl_t rem_q;
  logic [BEAT_W-1:0] beat_q;

  // Result queue, address and id shared by the lanes of one entry
  masku_pkg::elen_t [DEPTH-1:0][LANES-1:0] wdata_q;
  masku_pkg::strb_t [DEPTH-1:0][LANES-1:0] be_q;
  masku_pkg::vaddr_t [DEPTH-1:0] addr_q;
  masku_pkg::vid_t [DEPTH-1:0] id_q;
  logic [DEPTH-1:0][LANES-1:0] vld_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0] cnt_q;

  masku_pkg::elen_t [LANES-1:0] bit_en;
  masku_pkg::elen_t [LANES-1:0] merged;
  masku_pkg::strb_t [LANES-1:0] be;
  logic [LANES-1:0] left;
  logic full;
  logic push;
  logic last_beat;
  logic retire;
  logic done;

  assign full = (cnt_q == DEPTH);
  assign last_beat = (rem_q <= BEAT_ELEMS);

  // Mask operand only needed for masked instructions
  assign push = (state_q == masku_pkg::ST_RUN) && !full && (&a_valid_i) && (&b_valid_i) &&
                (insn.insn.vm || (&m_valid_i));
  assign a_ready_o = {LANES{push}};
  assign b_ready_o = {LANES{push}};
  assign m_ready_o = push && !insn.insn.vm;

  // rem_q counts elements from the start of this beat
  always_comb begin : p_merge
    for (int l = 0; l < LANES; l++) begin
      for (int k = 0; k < ELEN; k++) begin
        bit_en[l][k] = ((l * ELEN + k) < rem_q) && (insn.insn.vm || m_i[l][k]);
      end
      // A byte is written when its first element is inside vl
      for (int j = 0; j < `MASKU_STRB_W; j++) begin
        be[l][j] = (l * ELEN + 8 * j) < rem_q;
      end
      merged[l] = (a_i[l] & bit_en[l]) | (b_i[l] & ~bit_en[l]);
    end
  end

  // Head entry drives every lane port
  always_comb begin : p_wr_port
    for (int l = 0; l < LANES; l++) begin
      wr.req[l]   = vld_q[rd_ptr_q][l];
      wr.wdata[l] = wdata_q[rd_ptr_q][l];
      wr.be[l]    = be_q[rd_ptr_q][l];
      wr.addr[l]  = addr_q[rd_ptr_q];
      wr.id[l]    = id_q[rd_ptr_q];
    end
  end

  // Lanes still waiting for a grant after this cycle
  assign left = vld_q[rd_ptr_q] & ~wr.gnt;
  assign retire = (cnt_q != '0) && (left == '0);
  assign done = (state_q == masku_pkg::ST_DRAIN) &&
                ((cnt_q == '0) || (retire && (cnt_q == 1)));
  assign insn.logic_done = done;

  always_ff @(posedge clk_i) begin : p_payload
    if (push) begin
      wdata_q[wr_ptr_q] <= merged;
      be_q[wr_ptr_q]    <= be;
      addr_q[wr_ptr_q]  <= insn.insn.vd + masku_pkg::vaddr_t'(beat_q);
      id_q[wr_ptr_q]    <= insn.insn.id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      state_q  <= masku_pkg::ST_IDLE;
      rem_q    <= '0;
      beat_q   <= '0;
      vld_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Each lane clears its bit on grant
      vld_q[rd_ptr_q] <= left;
      if (retire) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push) begin
        vld_q[wr_ptr_q] <= '1;
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        beat_q   <= beat_q + 1'b1;
        rem_q    <= last_beat ? '0 : rem_q - masku_pkg::vl_t'(BEAT_ELEMS);
      end
      unique case ({push, retire})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;
      endcase
      case (state_q)
        masku_pkg::ST_IDLE: begin
          if (insn.logic_start) begin
            rem_q   <= insn.insn.vl;
            beat_q  <= '0;
            state_q <= (insn.insn.vl == '0) ? masku_pkg::ST_DRAIN : masku_pkg::ST_RUN;
          end
        end
        masku_pkg::ST_RUN: begin
          if (push && last_beat) begin
            state_q <= masku_pkg::ST_DRAIN;
          end
        end
        masku_pkg::ST_DRAIN: begin
          // Wait for the last entry to leave every lane
          if (done) begin
            state_q <= masku_pkg::ST_IDLE;
          end
        end
        default: state_q <= masku_pkg::ST_IDLE;
      endcase
    end
  end

  // A new result only lands on a slot every lane has drained
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> !(|vld_q[wr_ptr_q]));

endmodule

// File: hdl/mask_distributor.sv
/* Predicate path: expands mask operand beats into per-lane byte strobes
   through a two-entry mask queue per lane */

`include "masku_defines.svh"

module mask_distributor (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  insn_if.path_pred                                 insn,
  // Mask operand
  input  masku_pkg::elen_t [`MASKU_NR_LANES-1:0]    m_i,
  input  logic [`MASKU_NR_LANES-1:0]                m_valid_i,
  output logic                                      m_ready_o,
  // Strobes towards the functional units
  output masku_pkg::strb_t [`MASKU_NR_LANES-1:0]    mask_o,
  output logic [`MASKU_NR_LANES-1:0]                mask_valid_o,
  input  logic [`MASKU_NR_LANES-1:0]                mask_ready_i
);

  localparam int unsigned LANES = `MASKU_NR_LANES;
  localparam int unsigned DEPTH = `MASKU_QUEUE_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  // 8-bit elements, one strobe bit per element
  localparam int unsigned OUT_ELEMS = LANES * 8;
  localparam int unsigned SUB_BEATS = LANES * `MASKU_ELEN / OUT_ELEMS;
  localparam int unsigned SUB_W = $clog2(SUB_BEATS);

  masku_pkg::path_state_e state_q;
  masku_pkg::vl_t rem_q;
  logic [SUB_W-1:0] sub_q;

  // Mask queue
  masku_pkg::strb_t [DEPTH-1:0][LANES-1:0] strb_q;
  logic [DEPTH-1:0][LANES-1:0] vld_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0] cnt_q;

  logic [LANES*`MASKU_ELEN-1:0] m_flat;
  masku_pkg::strb_t [LANES-1:0] strb;
  logic [LANES-1:0] left;
  logic full;
  logic push;
  logic last_beat;
  logic retire;
  logic done;

  assign m_flat = m_i;
  assign full = (cnt_q == DEPTH);
  assign last_beat = (rem_q <= OUT_ELEMS);

  // All lanes of the mask operand must be present
  assign push = (state_q == masku_pkg::ST_RUN) && !full && (&m_valid_i);

  // Operand consumed after its eighth strobe beat or the final one
  assign m_ready_o = push && (last_beat || (sub_q == SUB_W'(SUB_BEATS - 1)));

  // Element sub_q*16 + l*8 + j, cleared past vl
  always_comb begin : p_strobe
    for (int l = 0; l < LANES; l++) begin
      for (int j = 0; j < 8; j++) begin
        strb[l][j] = m_flat[sub_q * OUT_ELEMS + l * 8 + j] && ((l * 8 + j) < rem_q);
      end
    end
  end

  // Head entry per lane
  assign mask_valid_o = vld_q[rd_ptr_q];
  assign mask_o = strb_q[rd_ptr_q];

  // Lanes still waiting after this cycle's handshakes
  assign left = vld_q[rd_ptr_q] & ~mask_ready_i;
  assign retire = (cnt_q != '0) && (left == '0);
  assign done = (state_q == masku_pkg::ST_DRAIN) &&
                ((cnt_q == '0) || (retire && (cnt_q == 1)));
  assign insn.pred_done = done;

  always_ff @(posedge clk_i) begin : p_payload
    if (push) begin
      strb_q[wr_ptr_q] <= strb;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      state_q  <= masku_pkg::ST_IDLE;
      rem_q    <= '0;
      sub_q    <= '0;
      vld_q    <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Lanes drop the head entry one by one
      vld_q[rd_ptr_q] <= left;
      if (retire) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push) begin
        vld_q[wr_ptr_q] <= '1;
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        sub_q    <= sub_q + 1'b1;
        rem_q    <= last_beat ? '0 : rem_q - masku_pkg::vl_t'(OUT_ELEMS);
      end
      unique case ({push, retire})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;
      endcase
      case (state_q)
        masku_pkg::ST_IDLE: begin
          if (insn.pred_start) begin
            rem_q   <= insn.insn.vl;
            sub_q   <= '0;
            state_q <= (insn.insn.vl == '0) ? masku_pkg::ST_DRAIN : masku_pkg::ST_RUN;
          end
        end
        masku_pkg::ST_RUN: begin
          if (push && last_beat) begin
            state_q <= masku_pkg::ST_DRAIN;
          end
        end
        masku_pkg::ST_DRAIN: begin
          if (done) begin
            state_q <= masku_pkg::ST_IDLE;
          end
        end
        default: state_q <= masku_pkg::ST_IDLE;
      endcase
    end
  end

  // A new beat only lands on a slot every lane has drained
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> !(|vld_q[wr_ptr_q]));

  // Strobes hold until the lane takes them
  for (genvar l = 0; l < LANES; l++) begin : g_hold_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      mask_valid_o[l] && !mask_ready_i[l] |=> mask_valid_o[l] && $stable(mask_o[l]));
  end

endmodule

// File: hdl/masku_sequencer.sv
/* Instruction sequencer: one-entry instruction register, opcode decode
   into path start pulses, done response from the active path */

module masku_sequencer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Instruction request
  input  logic                   insn_valid_i,
  output logic                   insn_ready_o,
  input  masku_pkg::masku_insn_t insn_i,
  // Completion response
  output logic                   done_valid_o,
  output masku_pkg::vid_t        done_id_o,
  // Broadcast to both paths
  insn_if.seq                    insn_o
);

  masku_pkg::masku_insn_t insn_q;
  logic busy_q;
  logic start_q;
  logic accept;
  logic path_done;

  // One instruction in flight at a time
  assign insn_ready_o = !busy_q;
  assign accept = insn_valid_i && !busy_q;

  // Opcode decode, so the paths never look at op
  assign insn_o.insn = insn_q;
  assign insn_o.logic_start = start_q && (insn_q.op == masku_pkg::OP_MASK_LOGIC);
  assign insn_o.pred_start = start_q && (insn_q.op == masku_pkg::OP_PREDICATE);

  // Only the owning path may finish the instruction
  assign path_done = (insn_q.op == masku_pkg::OP_MASK_LOGIC) ? insn_o.logic_done
                                                              : insn_o.pred_done;

  // Instruction register
  always_ff @(posedge clk_i) begin : p_insn
    if (accept) begin
      insn_q <= insn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      start_q      <= 1'b0;
      done_valid_o <= 1'b0;
      done_id_o    <= '0;
    end else begin
      // Start fires in the cycle after acceptance
      start_q      <= accept;
      done_valid_o <= busy_q && path_done;
      if (busy_q && path_done) begin
        busy_q    <= 1'b0;
        done_id_o <= insn_q.id;
      end
      if (accept) begin
        busy_q <= 1'b1;
      end
    end
  end

  // Paths only finish an instruction that was handed out
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !busy_q |-> !(insn_o.logic_done || insn_o.pred_done));

endmodule

// File: hdl/masku_if.sv
/* insn_if: instruction broadcast and path completion
   vrf_wr_if: per-lane result writes with request/grant */

`include "masku_defines.svh"

interface insn_if;

  masku_pkg::masku_insn_t insn;
  // One-cycle pulses per path
  logic logic_start;
  logic pred_start;
  logic logic_done;
  logic pred_done;

  modport seq (
    output insn, logic_start, pred_start,
    input  logic_done, pred_done
  );

  modport path_logic (
    input  insn, logic_start,
    output logic_done
  );

  modport path_pred (
    input  insn, pred_start,
    output pred_done
  );

endinterface

interface vrf_wr_if;

  // One write port per lane
  logic [`MASKU_NR_LANES-1:0] req;
  logic [`MASKU_NR_LANES-1:0] gnt;
  masku_pkg::vaddr_t [`MASKU_NR_LANES-1:0] addr;
  masku_pkg::elen_t [`MASKU_NR_LANES-1:0] wdata;
  masku_pkg::strb_t [`MASKU_NR_LANES-1:0] be;
  masku_pkg::vid_t [`MASKU_NR_LANES-1:0] id;

  modport src (
    output req, addr, wdata, be, id,
    input  gnt
  );

  modport dst (
    input  req, addr, wdata, be, id,
    output gnt
  );

endinterface

// File: hdl/masku_pkg.sv
/* Scalar types, opcode and path state enums, instruction struct */

`include "masku_defines.svh"

package masku_pkg;

  // One lane word and its byte strobes
  typedef logic [`MASKU_ELEN-1:0] elen_t;
  typedef logic [`MASKU_STRB_W-1:0] strb_t;

  // Element count, instruction id, register-file word address
  typedef logic [`MASKU_VL_W-1:0] vl_t;
  typedef logic [`MASKU_ID_W-1:0] vid_t;
  typedef logic [`MASKU_ADDR_W-1:0] vaddr_t;

  // Operations of the mask unit
  typedef enum logic [8:0] {
    OP_MASK_LOGIC = 9'd0,
    OP_PREDICATE  = 9'd1
  } masku_op_e;

  // Progress of each path through one instruction
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DRAIN
  } path_state_e;

  // 32-bit instruction word from the sequencer
  typedef struct packed {
    masku_op_e op;
    vl_t       vl;
    logic      vm;  // Low when the operation is masked
    vaddr_t    vd;
    vid_t      id;
  } masku_insn_t;

endpackage

// File: hdl/masku_defines.svh
/* Lane count, word widths, queue depth and vl limits of the mask unit */

`ifndef MASKU_DEFINES_SVH
`define MASKU_DEFINES_SVH

// Lane organisation
`define MASKU_NR_LANES 2
`define MASKU_ELEN 64
`define MASKU_STRB_W (`MASKU_ELEN / 8)

// Entries in every mask queue and result queue
`define MASKU_QUEUE_DEPTH 2

// Vector length
`define MASKU_MAX_VL 1024
`define MASKU_VL_W 11

// Instruction id and register-file word address
`define MASKU_ID_W 3
`define MASKU_ADDR_W 8

`endif
